// ==== hw/vec_params.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector unit sizes
// Register length, scalar width and register file geometry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// Bits per vector register
`define VEC_VLEN 64
// Scalar register width
`define VEC_XLEN 32
`define VEC_NREGS 32
`define VEC_RIDX_W 5

`endif

// ==== hw/vec_isa_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector ISA encodings
// Instruction formats and the opcode/funct constants of the subset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package vec_isa_pkg;

    // OP-V arithmetic format
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } vec_arith_fmt_t;

    // vsetvli format with vtype in zimm
    typedef struct packed {
        logic        zero;
        logic [10:0] zimm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } vec_cfg_fmt_t;

    typedef union packed {
        vec_arith_fmt_t arith;
        vec_cfg_fmt_t   cfg;
    } vec_instr_u;

    localparam logic [6:0] OP_V = 7'b1010111;

    localparam logic [2:0] OPIVV = 3'b000;
    localparam logic [2:0] OPMVV = 3'b010;
    localparam logic [2:0] OPIVX = 3'b100;
    localparam logic [2:0] OPMVX = 3'b110;
    localparam logic [2:0] OPCFG = 3'b111;

    localparam logic [5:0] F6_VADD      = 6'b000000;
    localparam logic [5:0] F6_VSUB      = 6'b000010;
    localparam logic [5:0] F6_VAND      = 6'b001001;
    localparam logic [5:0] F6_VOR       = 6'b001010;
    localparam logic [5:0] F6_VXOR      = 6'b001011;
    localparam logic [5:0] F6_VMV       = 6'b010111;
    localparam logic [5:0] F6_VMSEQ     = 6'b011000;
    // vmv.x.s lives here with vs1 = 0
    localparam logic [5:0] F6_VWXUNARY0 = 6'b010000;

endpackage

// ==== hw/vec_elem_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Element types
// Element width, ALU operation and vl types between stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vec_params.svh"

package vec_elem_pkg;

    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_t;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SEQ, OP_SPLAT, OP_V2X, OP_CFG, OP_NOP
    } alu_op_t;

    // Holds 0 up to VLEN/8 elements
    typedef logic [$clog2(`VEC_VLEN + 1)-1:0] vl_t;

endpackage

// ==== hw/vec_regfile.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector register file
// 32 registers, two asynchronous reads and one clocked write
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_regfile (
    input  logic                   clk,

    input  logic [`VEC_RIDX_W-1:0] rd_addr_a,
    input  logic [`VEC_RIDX_W-1:0] rd_addr_b,
    output logic [`VEC_VLEN-1:0]   rd_data_a,
    output logic [`VEC_VLEN-1:0]   rd_data_b,

    input  logic                   wr_en,
    input  logic [`VEC_RIDX_W-1:0] wr_addr,
    input  logic [`VEC_VLEN-1:0]   wr_data
);

    logic [`VEC_VLEN-1:0] regs [`VEC_NREGS];

    // Reads see the old value in the cycle of a write
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== hw/vec_decode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector decode stage
// Holds vtype/vl, stalls on RAW hazards, reads operands and
// registers the decoded operation for the ALU
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_decode (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    instr_valid,
    output logic                    instr_ready,
    input  vec_isa_pkg::vec_instr_u instr,
    input  logic [`VEC_XLEN-1:0]    scalar_rs1,

    output logic [`VEC_RIDX_W-1:0]  rd_addr_a,
    output logic [`VEC_RIDX_W-1:0]  rd_addr_b,
    input  logic [`VEC_VLEN-1:0]    rd_data_a,
    input  logic [`VEC_VLEN-1:0]    rd_data_b,

    input  logic                    pend_valid,
    input  logic [`VEC_RIDX_W-1:0]  pend_rd,

    output logic                    ex_valid,
    input  logic                    ex_ready,
    output vec_elem_pkg::alu_op_t   ex_op,
    output vec_elem_pkg::sew_t      ex_sew,
    output vec_elem_pkg::vl_t       ex_vl,
    output logic [`VEC_VLEN-1:0]    ex_src_a,
    output logic [`VEC_VLEN-1:0]    ex_src_b,
    output logic [`VEC_XLEN-1:0]    ex_scalar,
    output logic [`VEC_RIDX_W-1:0]  ex_rd
);

    import vec_isa_pkg::*;
    import vec_elem_pkg::*;

    alu_op_t op;
    logic    use_a;
    logic    use_b;
    logic    use_x;
    logic    ex_vec_dst;
    logic    hazard;
    logic    accept;
    sew_t    cur_sew;
    vl_t     cur_vl;
    sew_t    cfg_sew;
    vl_t     cfg_vl;
    vl_t     cfg_vlmax;

    assign rd_addr_a = instr.arith.vs2;
    assign rd_addr_b = instr.arith.vs1;

    always_comb begin
        op = OP_NOP;
        if (instr.arith.opcode == OP_V) begin
            case (instr.arith.funct3)
                OPIVV, OPIVX: begin
                    case (instr.arith.funct6)
                        F6_VADD: op = OP_ADD;
                        F6_VSUB: op = OP_SUB;
                        F6_VAND: op = OP_AND;
                        F6_VOR:  op = OP_OR;
                        F6_VXOR: op = OP_XOR;
                        F6_VMSEQ: begin
                            if (instr.arith.funct3 == OPIVV) op = OP_SEQ;
                        end
                        F6_VMV: begin
                            if (instr.arith.funct3 == OPIVX && instr.arith.vs2 == '0) begin
                                op = OP_SPLAT;
                            end
                        end
                        default: op = OP_NOP;
                    endcase
                end
                OPMVV: begin
                    if (instr.arith.funct6 == F6_VWXUNARY0 && instr.arith.vs1 == '0) begin
                        op = OP_V2X;
                    end
                end
                // No scalar-to-vector moves beyond the splat
                OPMVX: op = OP_NOP;
                OPCFG: begin
                    if (!instr.cfg.zero) op = OP_CFG;
                end
                default: op = OP_NOP;
            endcase
        end
    end

    assign use_b = (op != OP_NOP) && (instr.arith.funct3 == OPIVV);
    assign use_x = (op != OP_NOP) && (instr.arith.funct3 == OPIVX);
    assign use_a = !(op inside {OP_SPLAT, OP_CFG, OP_NOP});

    // vsew 3 treated as 32
    always_comb begin
        case (instr.cfg.zimm[5:3])
            3'd0:    cfg_sew = SEW8;
            3'd1:    cfg_sew = SEW16;
            default: cfg_sew = SEW32;
        endcase
        case (cfg_sew)
            SEW8:    cfg_vlmax = vl_t'(`VEC_VLEN / 8);
            SEW16:   cfg_vlmax = vl_t'(`VEC_VLEN / 16);
            default: cfg_vlmax = vl_t'(`VEC_VLEN / 32);
        endcase
        if (scalar_rs1 > `VEC_XLEN'(cfg_vlmax)) begin
            cfg_vl = cfg_vlmax;
        end else begin
            cfg_vl = vl_t'(scalar_rs1);
        end
    end

    // Scoreboard against both pipeline registers
    assign ex_vec_dst = ex_valid && !(ex_op inside {OP_V2X, OP_CFG, OP_NOP});
    assign hazard = instr_valid && (
        (use_a && ((ex_vec_dst && ex_rd == rd_addr_a) || (pend_valid && pend_rd == rd_addr_a))) ||
        (use_b && ((ex_vec_dst && ex_rd == rd_addr_b) || (pend_valid && pend_rd == rd_addr_b))));

    assign instr_ready = !hazard && (!ex_valid || ex_ready);
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            cur_sew  <= SEW8;
            cur_vl   <= '0;
        end else if (accept) begin
            ex_valid <= 1'b1;
            if (op == OP_CFG) begin
                cur_sew <= cfg_sew;
                cur_vl  <= cfg_vl;
            end
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    // Unused operand is zeroed so the ALU can merge vs1 and the scalar
    always_ff @(posedge clk) begin
        if (accept) begin
            ex_op     <= op;
            ex_sew    <= cur_sew;
            ex_vl     <= cur_vl;
            ex_src_a  <= rd_data_a;
            ex_src_b  <= use_b ? rd_data_b : '0;
            ex_scalar <= (op == OP_CFG) ? `VEC_XLEN'(cfg_vl) : (use_x ? scalar_rs1 : '0);
            ex_rd     <= instr.arith.vd;
        end
    end

endmodule

// ==== hw/vec_alu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector execute stage
// Lane-wise arithmetic, logic, compare and moves, tail zeroing
// and the result register that retires to the register file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_alu (
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   ex_valid,
    output logic                   ex_ready,
    input  vec_elem_pkg::alu_op_t  ex_op,
    input  vec_elem_pkg::sew_t     ex_sew,
    input  vec_elem_pkg::vl_t      ex_vl,
    input  logic [`VEC_VLEN-1:0]   ex_src_a,
    input  logic [`VEC_VLEN-1:0]   ex_src_b,
    input  logic [`VEC_XLEN-1:0]   ex_scalar,
    input  logic [`VEC_RIDX_W-1:0] ex_rd,

    output logic                   pend_valid,
    output logic [`VEC_RIDX_W-1:0] pend_rd,

    output logic                   wr_en,
    output logic [`VEC_RIDX_W-1:0] wr_addr,
    output logic [`VEC_VLEN-1:0]   wr_data,

    output logic                   res_valid,
    input  logic                   res_ready,
    output logic                   res_is_scalar,
    output logic [`VEC_RIDX_W-1:0] res_rd,
    output logic [`VEC_VLEN-1:0]   res_vec,
    output logic [`VEC_XLEN-1:0]   res_scalar
);

    import vec_elem_pkg::*;

    logic [5:0]                lane_w;
    logic [31:0]               lane_mask;
    logic [3:0]                n_lanes;
    logic [31:0]               a_lane;
    logic [31:0]               b_lane;
    logic [31:0]               lane_tmp;
    logic [`VEC_VLEN-1:0]      lane_res;
    logic [`VEC_VLEN/8-1:0]    seq_mask;
    logic [`VEC_XLEN-1:0]      elem0;
    logic [`VEC_VLEN-1:0]      vec_next;
    logic [`VEC_XLEN-1:0]      scalar_next;
    logic                      is_scalar;

    function automatic logic [31:0] lane_op(input alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            OP_ADD:   lane_op = a + b;
            OP_SUB:   lane_op = a - b;
            OP_AND:   lane_op = a & b;
            OP_OR:    lane_op = a | b;
            OP_XOR:   lane_op = a ^ b;
            OP_SPLAT: lane_op = b;
            default:  lane_op = '0;
        endcase
    endfunction

    always_comb begin
        case (ex_sew)
            SEW8: begin
                lane_w = 6'd8;  lane_mask = 32'h0000_00ff;
                n_lanes = 4'd8;
            end
            SEW16: begin
                lane_w = 6'd16; lane_mask = 32'h0000_ffff;
                n_lanes = 4'd4;
            end
            default: begin
                lane_w = 6'd32; lane_mask = 32'hffff_ffff;
                n_lanes = 4'd2;
            end
        endcase
    end

    // Decode zeroes whichever of vs1 and the scalar is unused,
    // so OR-ing the scalar into each lane replicates it for .vx
    always_comb begin
        lane_res = '0;
        seq_mask = '0;
        a_lane   = '0;
        b_lane   = '0;
        lane_tmp = '0;
        for (int i = 0; i < `VEC_VLEN / 8; i++) begin
            a_lane   = 32'(ex_src_a >> (i * lane_w)) & lane_mask;
            b_lane   = (32'(ex_src_b >> (i * lane_w)) | ex_scalar) & lane_mask;
            lane_tmp = lane_op(ex_op, a_lane, b_lane) & lane_mask;
            // Tail lanes stay zero
            if (i < n_lanes && i < ex_vl) begin
                lane_res    = lane_res | (`VEC_VLEN'(lane_tmp) << (i * lane_w));
                seq_mask[i] = (a_lane == b_lane);
            end
        end
    end

    always_comb begin
        case (ex_sew)
            SEW8:    elem0 = {{24{ex_src_a[7]}}, ex_src_a[7:0]};
            SEW16:   elem0 = {{16{ex_src_a[15]}}, ex_src_a[15:0]};
            default: elem0 = ex_src_a[31:0];
        endcase
    end

    always_comb begin
        is_scalar   = 1'b0;
        vec_next    = lane_res;
        scalar_next = '0;
        case (ex_op)
            OP_SEQ: vec_next = `VEC_VLEN'(seq_mask);
            OP_V2X: begin
                is_scalar   = 1'b1;
                vec_next    = '0;
                scalar_next = elem0;
            end
            // New vl computed in decode
            OP_CFG: begin
                is_scalar   = 1'b1;
                vec_next    = '0;
                scalar_next = ex_scalar;
            end
            OP_NOP: begin
                is_scalar = 1'b1;
                vec_next  = '0;
            end
            default: is_scalar = 1'b0;
        endcase
    end

    assign ex_ready = !res_valid || res_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else if (ex_ready) begin
            res_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && ex_ready) begin
            res_is_scalar <= is_scalar;
            res_rd        <= ex_rd;
            res_vec       <= vec_next;
            res_scalar    <= scalar_next;
        end
    end

    assign pend_valid = res_valid && !res_is_scalar;
    assign pend_rd    = res_rd;

    // Register changes when its result retires
    assign wr_en   = res_valid && res_ready && !res_is_scalar;
    assign wr_addr = res_rd;
    assign wr_data = res_vec;

endmodule

// ==== hw/vec_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector execution unit top
// Decode stage, vector register file and execute stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_unit (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    instr_valid,
    output logic                    instr_ready,
    input  vec_isa_pkg::vec_instr_u instr,
    input  logic [`VEC_XLEN-1:0]    scalar_rs1,

    output logic                    res_valid,
    input  logic                    res_ready,
    output logic                    res_is_scalar,
    output logic [`VEC_RIDX_W-1:0]  res_rd,
    output logic [`VEC_VLEN-1:0]    res_vec,
    output logic [`VEC_XLEN-1:0]    res_scalar
);

    import vec_elem_pkg::*;

    logic [`VEC_RIDX_W-1:0] rd_addr_a;
    logic [`VEC_RIDX_W-1:0] rd_addr_b;
    logic [`VEC_VLEN-1:0]   rd_data_a;
    logic [`VEC_VLEN-1:0]   rd_data_b;
    logic                   wr_en;
    logic [`VEC_RIDX_W-1:0] wr_addr;
    logic [`VEC_VLEN-1:0]   wr_data;
    logic                   pend_valid;
    logic [`VEC_RIDX_W-1:0] pend_rd;
    logic                   ex_valid;
    logic                   ex_ready;
    alu_op_t                ex_op;
    sew_t                   ex_sew;
    vl_t                    ex_vl;
    logic [`VEC_VLEN-1:0]   ex_src_a;
    logic [`VEC_VLEN-1:0]   ex_src_b;
    logic [`VEC_XLEN-1:0]   ex_scalar;
    logic [`VEC_RIDX_W-1:0] ex_rd;

    vec_decode u_decode (
        .clk, .arst_n,
        .instr_valid, .instr_ready, .instr, .scalar_rs1,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .pend_valid, .pend_rd,
        .ex_valid, .ex_ready, .ex_op, .ex_sew, .ex_vl,
        .ex_src_a, .ex_src_b, .ex_scalar, .ex_rd
    );

    vec_regfile u_regfile (
        .clk,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .wr_en, .wr_addr, .wr_data
    );

    vec_alu u_alu (
        .clk, .arst_n,
        .ex_valid, .ex_ready, .ex_op, .ex_sew, .ex_vl,
        .ex_src_a, .ex_src_b, .ex_scalar, .ex_rd,
        .pend_valid, .pend_rd,
        .wr_en, .wr_addr, .wr_data,
        .res_valid, .res_ready, .res_is_scalar, .res_rd, .res_vec, .res_scalar
    );

endmodule

// ==== dv/vec_unit_tests.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for the vector unit
// Instruction builders and one task per behavior
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic vec_instr_u enc_op(input logic [5:0] f6, input logic [2:0] f3,
                                      input logic [4:0] vd, input logic [4:0] vs2,
                                      input logic [4:0] vs1);
    vec_instr_u w;
    w = '0;
    w.arith.funct6 = f6;
    w.arith.vm     = 1'b1;
    w.arith.vs2    = vs2;
    w.arith.vs1    = vs1;
    w.arith.funct3 = f3;
    w.arith.vd     = vd;
    w.arith.opcode = OP_V;
    return w;
endfunction

// vsetvli with LMUL 1
function automatic vec_instr_u enc_cfg(input logic [2:0] vsew, input logic [4:0] rd);
    vec_instr_u w;
    w = '0;
    w.cfg.zimm   = {5'b0, vsew, 3'b000};
    w.cfg.rs1    = 5'd10;
    w.cfg.funct3 = OPCFG;
    w.cfg.rd     = rd;
    w.cfg.opcode = OP_V;
    return w;
endfunction

function automatic logic [5:0] pick_f6(input int j);
    case (j % 5)
        0:       return F6_VADD;
        1:       return F6_VSUB;
        2:       return F6_VAND;
        3:       return F6_VOR;
        default: return F6_VXOR;
    endcase
endfunction

function automatic logic [4:0] any_reg();
    return 5'(lfsr_bits(5));
endfunction

task automatic set_vtype(input logic [2:0] vsew, input logic [31:0] avl);
    queue_instr(enc_cfg(vsew, any_reg()), avl);
endtask

task automatic splat(input logic [4:0] vd, input logic [31:0] x);
    queue_instr(enc_op(F6_VMV, OPIVX, vd, 5'd0, 5'd11), x);
endtask

task automatic move_to_scalar(input logic [4:0] vs2);
    queue_instr(enc_op(F6_VWXUNARY0, OPMVV, any_reg(), vs2, 5'd0), '0);
endtask

// Lengths below and above VLEN/SEW including vsew 3
task automatic test_vsetvli();
    logic [31:0] avl;
    for (int s = 0; s < 4; s++) begin
        for (int k = 0; k < 4; k++) begin
            avl = (k == 3) ? 32'h8000_0001 : lfsr_bits(4);
            set_vtype(3'(s), avl);
            splat(5'(k + 1), lfsr_bits(32));
        end
        run_queue(1'b0);
    end
endtask

task automatic test_alu_ops();
    set_vtype(3'd0, 32'd64);
    for (int r = 0; r < `VEC_NREGS; r++) begin
        splat(5'(r), lfsr_bits(32));
    end
    // Short 16-bit splats so lanes differ
    set_vtype(3'd1, 32'd1);
    for (int r = 0; r < `VEC_NREGS; r += 3) begin
        splat(5'(r), lfsr_bits(32));
    end
    run_queue(1'b0);
    for (int s = 0; s < 3; s++) begin
        set_vtype(3'(s), lfsr_bits(4) + 32'd1);
        for (int j = 0; j < 5; j++) begin
            queue_instr(enc_op(pick_f6(j), OPIVV, any_reg(), any_reg(), any_reg()), '0);
            queue_instr(enc_op(pick_f6(j), OPIVX, any_reg(), any_reg(), 5'd12),
                        lfsr_bits(32));
        end
        run_queue(1'b0);
    end
endtask

task automatic test_vmseq();
    logic [31:0] k;
    for (int s = 0; s < 3; s++) begin
        k = lfsr_bits(3);
        set_vtype(3'(s), 32'd64);
        splat(5'd5, lfsr_bits(32) | 32'h0001_0101);
        // v7 equals v5 below element k and is zero above
        set_vtype(3'(s), k);
        queue_instr(enc_op(F6_VXOR, OPIVX, 5'd7, 5'd5, 5'd12), '0);
        set_vtype(3'(s), 32'd64);
        queue_instr(enc_op(F6_VMSEQ, OPIVV, 5'd6, 5'd5, 5'd7), '0);
        queue_instr(enc_op(F6_VMSEQ, OPIVV, 5'd8, 5'd5, 5'd5), '0);
        queue_instr(enc_op(F6_VMSEQ, OPIVV, any_reg(), any_reg(), any_reg()), '0);
        run_queue(1'b0);
    end
endtask

task automatic test_move_to_scalar();
    for (int s = 0; s < 3; s++) begin
        set_vtype(3'(s), 32'd64);
        splat(5'd9, lfsr_bits(32) | 32'h8080_8080);
        move_to_scalar(5'd9);
        splat(5'd9, lfsr_bits(32) & 32'h7f7f_7f7f);
        move_to_scalar(5'd9);
        move_to_scalar(any_reg());
        run_queue(1'b0);
    end
endtask

// Dependent chain under random result stalls
task automatic test_dependent_stall();
    logic [4:0] prev;
    logic [4:0] next;
    set_vtype(3'(lfsr_bits(2)), 32'd64);
    prev = any_reg();
    for (int k = 0; k < 16; k++) begin
        next = any_reg();
        if (lfsr_bits(1) != 32'd0) begin
            queue_instr(enc_op(pick_f6(int'(lfsr_bits(3))), OPIVV, next, prev, prev), '0);
        end else begin
            queue_instr(enc_op(pick_f6(int'(lfsr_bits(3))), OPIVX, next, prev, 5'd12),
                        lfsr_bits(32));
        end
        if (k % 4 == 3) begin
            move_to_scalar(next);
        end
        prev = next;
    end
    run_queue(1'b1);
endtask

task automatic test_unsupported();
    vec_instr_u w;
    set_vtype(3'd0, 32'd64);
    // vmul.vv
    queue_instr(enc_op(6'b100101, OPMVV, 5'd3, 5'd4, 5'd5), lfsr_bits(32));
    queue_instr(enc_op(F6_VADD, OPMVX, 5'd6, 5'd7, 5'd8), lfsr_bits(32));
    queue_instr(enc_op(F6_VMSEQ, OPIVX, 5'd9, 5'd10, 5'd11), lfsr_bits(32));
    w = enc_op(F6_VADD, OPIVV, 5'd12, 5'd13, 5'd14);
    w.arith.opcode = 7'b0110011;
    queue_instr(w, '0);
    // vsetvl form must leave vtype alone
    w = enc_cfg(3'd2, 5'd15);
    w.cfg.zero = 1'b1;
    queue_instr(w, 32'd1);
    for (int r = 0; r < `VEC_NREGS; r++) begin
        queue_instr(enc_op(F6_VADD, OPIVX, 5'(r), 5'(r), 5'd12), '0);
    end
    run_queue(1'b0);
endtask

// ==== dv/vec_unit_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector unit testbench
// Clock, reset, DUT, reference model, issue/collect and checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "vec_params.svh"

module vec_unit_tb;

    import vec_isa_pkg::*;
    import vec_elem_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic                   clk;
    logic                   arst_n;
    logic                   instr_valid;
    logic                   instr_ready;
    vec_instr_u             instr;
    logic [`VEC_XLEN-1:0]   scalar_rs1;
    logic                   res_valid;
    logic                   res_ready;
    logic                   res_is_scalar;
    logic [`VEC_RIDX_W-1:0] res_rd;
    logic [`VEC_VLEN-1:0]   res_vec;
    logic [`VEC_XLEN-1:0]   res_scalar;

    logic [31:0]            lfsr_state;
    // Register file and vtype as the program sees them
    logic [`VEC_VLEN-1:0]   model_regs [`VEC_NREGS];
    int                     model_sew;
    int                     model_vl;

    // Pending issues and expected results
    vec_instr_u             issue_q [$];
    logic [`VEC_XLEN-1:0]   issue_rs1_q [$];
    logic                   exp_scalar_q [$];
    logic [`VEC_RIDX_W-1:0] exp_rd_q [$];
    logic [`VEC_VLEN-1:0]   exp_vec_q [$];
    logic [`VEC_XLEN-1:0]   exp_sc_q [$];

    vec_unit dut0 (
        .clk, .arst_n,
        .instr_valid, .instr_ready, .instr, .scalar_rs1,
        .res_valid, .res_ready, .res_is_scalar, .res_rd, .res_vec, .res_scalar
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic complain(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_vec(input string name, input logic [`VEC_VLEN-1:0] got,
                             input logic [`VEC_VLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_scalar(input string name, input logic [`VEC_XLEN-1:0] got,
                                input logic [`VEC_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_rd(input string name, input logic [`VEC_RIDX_W-1:0] got,
                            input logic [`VEC_RIDX_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [31:0] sew_mask();
        return (model_sew == 32) ? 32'hffff_ffff : ((32'd1 << model_sew) - 32'd1);
    endfunction

    function automatic logic [31:0] lane_of(input logic [`VEC_VLEN-1:0] v, input int i);
        return 32'(v >> (i * model_sew)) & sew_mask();
    endfunction

    // Subset member of an encoding
    function automatic alu_op_t classify(input vec_instr_u ins);
        vec_arith_fmt_t f;
        f = ins.arith;
        if (f.opcode != OP_V) begin
            return OP_NOP;
        end
        if (f.funct3 == OPCFG) begin
            return ins.cfg.zero ? OP_NOP : OP_CFG;
        end
        if (f.funct3 == OPMVV) begin
            return (f.funct6 == F6_VWXUNARY0 && f.vs1 == 5'd0) ? OP_V2X : OP_NOP;
        end
        if (f.funct3 != OPIVV && f.funct3 != OPIVX) begin
            return OP_NOP;
        end
        case (f.funct6)
            F6_VADD:  return OP_ADD;
            F6_VSUB:  return OP_SUB;
            F6_VAND:  return OP_AND;
            F6_VOR:   return OP_OR;
            F6_VXOR:  return OP_XOR;
            F6_VMSEQ: return (f.funct3 == OPIVV) ? OP_SEQ : OP_NOP;
            F6_VMV:   return (f.funct3 == OPIVX && f.vs2 == 5'd0) ? OP_SPLAT : OP_NOP;
            default:  return OP_NOP;
        endcase
    endfunction

    task automatic model_step(input vec_instr_u ins, input logic [`VEC_XLEN-1:0] rs1);
        alu_op_t              kind;
        logic [`VEC_VLEN-1:0] a;
        logic [`VEC_VLEN-1:0] b;
        logic [`VEC_VLEN-1:0] r;
        logic [31:0]          ea;
        logic [31:0]          eb;
        logic [31:0]          er;
        logic [`VEC_XLEN-1:0] sc;
        int                   vlmax;
        kind  = classify(ins);
        a     = model_regs[ins.arith.vs2];
        b     = model_regs[ins.arith.vs1];
        vlmax = `VEC_VLEN / model_sew;
        r     = '0;
        sc    = '0;
        case (kind)
            OP_CFG: begin
                case (ins.cfg.zimm[5:3])
                    3'd0:    model_sew = 8;
                    3'd1:    model_sew = 16;
                    default: model_sew = 32;
                endcase
                vlmax    = `VEC_VLEN / model_sew;
                model_vl = (rs1 > vlmax) ? vlmax : int'(rs1);
                sc       = model_vl;
            end
            OP_V2X: begin
                ea = a[31:0] & sew_mask();
                sc = ea[model_sew-1] ? (ea | ~sew_mask()) : ea;
            end
            OP_NOP: sc = '0;
            default: begin
                for (int i = 0; i < vlmax; i++) begin
                    ea = lane_of(a, i);
                    eb = (ins.arith.funct3 == OPIVX) ? (rs1 & sew_mask()) : lane_of(b, i);
                    case (kind)
                        OP_ADD:  er = ea + eb;
                        OP_SUB:  er = ea - eb;
                        OP_AND:  er = ea & eb;
                        OP_OR:   er = ea | eb;
                        OP_XOR:  er = ea ^ eb;
                        OP_SEQ:  er = {31'b0, ea == eb};
                        default: er = eb;
                    endcase
                    // Tail elements stay zero
                    if (i < model_vl && kind == OP_SEQ) begin
                        r[i] = er[0];
                    end else if (i < model_vl) begin
                        r = r | (`VEC_VLEN'(er & sew_mask()) << (i * model_sew));
                    end
                end
                model_regs[ins.arith.vd] = r;
            end
        endcase
        exp_scalar_q.push_back(kind inside {OP_CFG, OP_V2X, OP_NOP});
        exp_rd_q.push_back(ins.arith.vd);
        exp_vec_q.push_back(r);
        exp_sc_q.push_back(sc);
    endtask

    task automatic queue_instr(input vec_instr_u ins, input logic [`VEC_XLEN-1:0] rs1);
        model_step(ins, rs1);
        issue_q.push_back(ins);
        issue_rs1_q.push_back(rs1);
    endtask

    // Ready sampled 1 ns after the falling edge
    task automatic issue_all();
        int waited;
        while (issue_q.size() > 0) begin
            @(negedge clk);
            instr_valid = 1'b1;
            instr       = issue_q[0];
            scalar_rs1  = issue_rs1_q[0];
            waited      = 0;
            #1;
            while (!instr_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    complain("instr_ready stayed low past the timeout");
                end
                @(negedge clk);
                #1;
            end
            void'(issue_q.pop_front());
            void'(issue_rs1_q.pop_front());
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic collect(input int n, input logic stall);
        int waited;
        int hold;
        hold = 0;
        while (n > 0) begin
            waited = 0;
            do begin
                @(negedge clk);
                if (hold > 0) begin
                    res_ready = 1'b0;
                    hold--;
                end else if (stall && lfsr_bits(2) == 32'd0) begin
                    res_ready = 1'b0;
                    hold = int'(lfsr_bits(3));
                end else begin
                    res_ready = 1'b1;
                end
                waited++;
                if (waited > WAIT_LIMIT) begin
                    complain("no result arrived within the timeout");
                end
            end while (!(res_valid && res_ready));
            check_flag("res_is_scalar", res_is_scalar, exp_scalar_q[0]);
            check_rd("res_rd", res_rd, exp_rd_q[0]);
            if (exp_scalar_q[0]) begin
                check_scalar("res_scalar", res_scalar, exp_sc_q[0]);
            end else begin
                check_vec("res_vec", res_vec, exp_vec_q[0]);
            end
            void'(exp_scalar_q.pop_front());
            void'(exp_rd_q.pop_front());
            void'(exp_vec_q.pop_front());
            void'(exp_sc_q.pop_front());
            n--;
        end
        @(negedge clk);
        res_ready = 1'b0;
    endtask

    task automatic run_queue(input logic stall);
        int n;
        n = issue_q.size();
        fork
            issue_all();
            collect(n, stall);
        join
    endtask

    `include "vec_unit_tests.svh"

    initial begin
        lfsr_state  = 32'hef43;
        model_sew   = 8;
        model_vl    = 0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        scalar_rs1  = '0;
        res_ready   = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_flag("instr_ready", instr_ready, 1'b1);
        check_flag("res_valid", res_valid, 1'b0);
        test_vsetvli();
        test_alu_ops();
        test_vmseq();
        test_move_to_scalar();
        test_dependent_stall();
        test_unsupported();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
+incdir+dv
hw/vec_isa_pkg.sv
hw/vec_elem_pkg.sv
hw/vec_regfile.sv
hw/vec_decode.sv
hw/vec_alu.sv
hw/vec_unit.sv
dv/vec_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the vector unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module vec_unit_tb -o vec_unit_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/vec_unit_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
